//--- enable_gen.f
hdl/enable_gen_pkg.sv
hdl/bus_write_fsm.sv
hdl/period_counter.sv
hdl/enable_comparator.sv
hdl/enable_gen_top.sv
test/tb_clock_gen.sv
test/tb_enable_gen.sv

//--- build.sh
#!/bin/sh
# Compile and run the enable generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log
SIM_BIN=tb_enable_gen_sim

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_enable_gen \
    --Mdir "$BUILD_DIR" -o "$SIM_BIN" \
    -f enable_gen.f > "$BUILD_LOG" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status, see $BUILD_LOG"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "^No errors$" "$SIM_LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

//--- test/tb_enable_gen.sv
`timescale 1ns/100ps

module tb_enable_gen;

    import enable_gen_pkg::*;

    localparam int DUT_COUNT_WIDTH = 16;
    localparam addr_t DUT_BASE_ADDRESS = 32'h0000_0100;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    // Run length budget
    localparam int NUM_RANDOM_OPS = 300;
    localparam int MAX_OP_CYCLES = 34;
    localparam int DIRECTED_CYCLES = 500;
    localparam int TIMEOUT_CYCLES = NUM_RANDOM_OPS * MAX_OP_CYCLES + DIRECTED_CYCLES + 100;

    logic clock;
    logic reset;
    logic gen_enable;
    logic write_strobe;
    addr_t address;
    data_t write_data;
    logic ready;
    logic enable_1;
    logic enable_2;

    logic [31:0] lfsr_state;
    int cycle_count;
    logic checks_enabled;

    // Reference model state
    logic model_ready;
    logic model_apply;
    addr_t model_address;
    data_t model_data;
    logic model_run;
    logic [DUT_COUNT_WIDTH-1:0] model_period;
    logic [DUT_COUNT_WIDTH-1:0] model_threshold_1;
    logic [DUT_COUNT_WIDTH-1:0] model_threshold_2;
    logic [DUT_COUNT_WIDTH-1:0] model_count;
    logic model_counting;
    logic model_enable_1;
    logic model_enable_2;

    tb_clock_gen u_tb_clock_gen (
        .clock(clock),
        .reset(reset)
    );

    enable_gen_top #(
        .BASE_ADDRESS(DUT_BASE_ADDRESS),
        .COUNT_WIDTH(DUT_COUNT_WIDTH)
    ) u_enable_gen_top (
        .clock(clock),
        .reset(reset),
        .gen_enable(gen_enable),
        .write_strobe(write_strobe),
        .address(address),
        .write_data(write_data),
        .ready(ready),
        .enable_1(enable_1),
        .enable_2(enable_2)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic [31:0] next_state;
        next_state = state >> 1;
        if (state[0]) begin
            next_state = next_state ^ LFSR_TAPS;
        end
        return next_state;
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int bit_count, output logic [31:0] value);
        logic [31:0] result;
        result = '0;
        for (int i = 0; i < bit_count; i++) begin
            result[i] = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
        value = result;
    endtask

    // Value 0 to 31 with junk above the counter width
    task automatic small_word(output data_t word);
        logic [31:0] high_bits;
        logic [31:0] low_bits;
        take_bits(16, high_bits);
        take_bits(5, low_bits);
        word = {high_bits[15:0], 11'b0, low_bits[4:0]};
    endtask

    task automatic unmapped_address(output addr_t target);
        logic [31:0] pick;
        logic [31:0] bits;
        take_bits(2, pick);
        case (pick[1:0])
            2'd0: target = DUT_BASE_ADDRESS + 32'h10;
            2'd1: target = DUT_BASE_ADDRESS + 32'h6;
            2'd2: target = PERIOD_OFFSET;
            default: begin
                take_bits(32, bits);
                target = bits;
            end
        endcase
    endtask

    task automatic stop_with_failure();
        $display("Errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_ready(input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("mismatch ready: got %h, expected %h", actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic compare_enable(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("mismatch %s: got %h, expected %h", name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic compare_count(input count_t actual, input count_t expected);
        if (actual !== expected) begin
            $display("mismatch count: got %h, expected %h", actual, expected);
            stop_with_failure();
        end
    endtask

    // Model advances on the rising edge, from the old values only
    always @(posedge clock) begin
        if (!reset) begin
            model_ready = 1'b1;
            model_apply = 1'b0;
            model_run = 1'b0;
            model_period = '0;
            model_threshold_1 = '0;
            model_threshold_2 = '0;
            model_count = '0;
            model_counting = 1'b0;
            model_enable_1 = 1'b0;
            model_enable_2 = 1'b0;
        end else begin
            checks_enabled = 1'b1;
            model_enable_1 = model_counting && (model_count == model_threshold_1);
            model_enable_2 = model_counting && (model_count == model_threshold_2);
            if (model_run || gen_enable) begin
                model_counting = 1'b1;
                model_count = (model_count >= model_period) ? '0 : model_count + 16'd1;
            end else begin
                model_counting = 1'b0;
                model_count = '0;
            end
            if (model_apply) begin
                if (model_address == DUT_BASE_ADDRESS + CTRL_OFFSET) begin
                    model_run = model_data[0];
                end else if (model_address == DUT_BASE_ADDRESS + PERIOD_OFFSET) begin
                    model_period = model_data[DUT_COUNT_WIDTH-1:0];
                end else if (model_address == DUT_BASE_ADDRESS + THRESH1_OFFSET) begin
                    model_threshold_1 = model_data[DUT_COUNT_WIDTH-1:0];
                end else if (model_address == DUT_BASE_ADDRESS + THRESH2_OFFSET) begin
                    model_threshold_2 = model_data[DUT_COUNT_WIDTH-1:0];
                end
                model_apply = 1'b0;
            end else if (write_strobe) begin
                model_address = address;
                model_data = write_data;
                model_apply = 1'b1;
            end
            model_ready = !model_apply;
        end
    end

    // Outputs are settled by the falling edge
    always @(negedge clock) begin
        if (checks_enabled) begin
            compare_ready(ready, model_ready);
            compare_enable("enable_1", enable_1, model_enable_1);
            compare_enable("enable_2", enable_2, model_enable_2);
            compare_count(u_enable_gen_top.count, count_t'(model_count));
        end
    end

    always @(negedge clock) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_with_failure();
        end
    end

    task automatic idle_cycles(input int cycles);
        write_strobe = 1'b0;
        repeat (cycles) @(negedge clock);
    endtask

    // Extra strobe lands in the apply cycle and must be dropped
    task automatic bus_write(input addr_t target, input data_t word, input logic extra_strobe);
        logic [31:0] bits;
        while (ready !== 1'b1) begin
            @(negedge clock);
        end
        write_strobe = 1'b1;
        address = target;
        write_data = word;
        @(negedge clock);
        if (extra_strobe) begin
            take_bits(32, bits);
            address = DUT_BASE_ADDRESS + PERIOD_OFFSET;
            write_data = bits;
        end else begin
            write_strobe = 1'b0;
        end
        @(negedge clock);
        write_strobe = 1'b0;
    endtask

    task automatic run_directed_checks();
        // Quiet after reset
        idle_cycles(20);
        // Run bit with both thresholds inside the period
        bus_write(DUT_BASE_ADDRESS + THRESH1_OFFSET, 32'd3, 1'b0);
        bus_write(DUT_BASE_ADDRESS + THRESH2_OFFSET, 32'd7, 1'b0);
        bus_write(DUT_BASE_ADDRESS + PERIOD_OFFSET, 32'd9, 1'b0);
        bus_write(DUT_BASE_ADDRESS + CTRL_OFFSET, 32'd1, 1'b0);
        idle_cycles(40);
        bus_write(DUT_BASE_ADDRESS + THRESH1_OFFSET, 32'd5, 1'b1);
        idle_cycles(20);
        // Handover from run bit to gen_enable
        bus_write(DUT_BASE_ADDRESS + CTRL_OFFSET, 32'd0, 1'b0);
        idle_cycles(10);
        gen_enable = 1'b1;
        idle_cycles(40);
        gen_enable = 1'b0;
        idle_cycles(10);
        // Unmapped writes and a threshold past the period
        bus_write(DUT_BASE_ADDRESS + 32'h10, 32'd2, 1'b0);
        bus_write(PERIOD_OFFSET, 32'd2, 1'b0);
        bus_write(DUT_BASE_ADDRESS + THRESH2_OFFSET, 32'h0001_0014, 1'b0);
        gen_enable = 1'b1;
        idle_cycles(30);
        // Period raised, then cut below the running count
        bus_write(DUT_BASE_ADDRESS + PERIOD_OFFSET, 32'd25, 1'b0);
        idle_cycles(20);
        bus_write(DUT_BASE_ADDRESS + PERIOD_OFFSET, 32'd4, 1'b0);
        idle_cycles(20);
        gen_enable = 1'b0;
        idle_cycles(5);
    endtask

    task automatic run_random_op();
        logic [31:0] kind;
        logic [31:0] extra;
        logic [31:0] pick;
        data_t word;
        addr_t target;
        take_bits(3, kind);
        take_bits(1, extra);
        small_word(word);
        case (kind[2:0])
            3'd0: bus_write(DUT_BASE_ADDRESS + THRESH1_OFFSET, word, extra[0]);
            3'd1: bus_write(DUT_BASE_ADDRESS + THRESH2_OFFSET, word, extra[0]);
            3'd2: bus_write(DUT_BASE_ADDRESS + PERIOD_OFFSET, word, extra[0]);
            3'd3: bus_write(DUT_BASE_ADDRESS + CTRL_OFFSET, word, extra[0]);
            3'd4: begin
                unmapped_address(target);
                bus_write(target, word, extra[0]);
            end
            3'd5: begin
                gen_enable = ~gen_enable;
                idle_cycles(1);
            end
            default: begin
                take_bits(5, pick);
                idle_cycles(int'(pick[4:0]) + 1);
            end
        endcase
    endtask

    initial begin
        gen_enable = 1'b0;
        write_strobe = 1'b0;
        address = '0;
        write_data = '0;
        lfsr_state = 32'hbca5;
        cycle_count = 0;
        checks_enabled = 1'b0;
        wait (reset === 1'b1);
        run_directed_checks();
        for (int op = 0; op < NUM_RANDOM_OPS; op++) begin
            run_random_op();
        end
        gen_enable = 1'b0;
        idle_cycles(40);
        $display("No errors");
        $finish;
    end

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 2,
    parameter int RESET_CYCLES = 10
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD_NS) clock = ~clock;
    end

    // Reset released on a falling edge, clear of the sampling edge
    initial begin
        reset = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
    end

endmodule

//--- hdl/enable_gen_top.sv
`timescale 1ns/100ps

module enable_gen_top #(
    parameter enable_gen_pkg::addr_t BASE_ADDRESS = '0,
    parameter int COUNT_WIDTH = enable_gen_pkg::COUNT_WIDTH
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  gen_enable,
    input  logic                  write_strobe,
    input  enable_gen_pkg::addr_t address,
    input  enable_gen_pkg::data_t write_data,
    output logic                  ready,
    output logic                  enable_1,
    output logic                  enable_2
);

    import enable_gen_pkg::*;

    count_t period;
    count_t threshold_1;
    count_t threshold_2;
    count_t count;
    logic run_bit;
    logic counting;
    logic count_enable;

    // Either source keeps the counter running
    assign count_enable = run_bit | gen_enable;

    bus_write_fsm #(
        .BASE_ADDRESS(BASE_ADDRESS),
        .COUNT_WIDTH(COUNT_WIDTH)
    ) u_bus_write_fsm (
        .clock(clock),
        .reset(reset),
        .write_strobe(write_strobe),
        .address(address),
        .write_data(write_data),
        .ready(ready),
        .run_bit(run_bit),
        .period(period),
        .threshold_1(threshold_1),
        .threshold_2(threshold_2)
    );

    period_counter #(
        .COUNT_WIDTH(COUNT_WIDTH)
    ) u_period_counter (
        .clock(clock),
        .reset(reset),
        .count_enable(count_enable),
        .period(period),
        .count(count),
        .counting(counting)
    );

    enable_comparator #(
        .COUNT_WIDTH(COUNT_WIDTH)
    ) u_comparator_1 (
        .clock(clock),
        .reset(reset),
        .count(count),
        .counting(counting),
        .threshold(threshold_1),
        .enable(enable_1)
    );

    enable_comparator #(
        .COUNT_WIDTH(COUNT_WIDTH)
    ) u_comparator_2 (
        .clock(clock),
        .reset(reset),
        .count(count),
        .counting(counting),
        .threshold(threshold_2),
        .enable(enable_2)
    );

endmodule

//--- hdl/enable_comparator.sv
`timescale 1ns/100ps

module enable_comparator #(
    parameter int COUNT_WIDTH = enable_gen_pkg::COUNT_WIDTH
) (
    input  logic                   clock,
    input  logic                   reset,
    input  enable_gen_pkg::count_t count,
    input  logic                   counting,
    input  enable_gen_pkg::count_t threshold,
    output logic                   enable
);

    logic match;

    // Count never passes the period, so a higher threshold never matches
    assign match = counting && (count[COUNT_WIDTH-1:0] == threshold[COUNT_WIDTH-1:0]);

    always_ff @(posedge clock) begin
        if (!reset) begin
            enable <= 1'b0;
        end else begin
            enable <= match;
        end
    end

    // Back to back pulses with a steady threshold mean the count sat at 0,
    // which the counter only does with a zero period
    single_pulse: assert property (
        @(posedge clock) disable iff (!reset)
        (enable && $past(enable) && ($past(threshold) == $past(threshold, 2)))
            |-> ($past(count) == '0)
    ) else $error("enable held high outside a zero period");

endmodule

//--- hdl/period_counter.sv
`timescale 1ns/100ps

module period_counter #(
    parameter int COUNT_WIDTH = enable_gen_pkg::COUNT_WIDTH
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   count_enable,
    input  enable_gen_pkg::count_t period,
    output enable_gen_pkg::count_t count,
    output logic                   counting
);

    import enable_gen_pkg::*;

    logic [COUNT_WIDTH-1:0] count_q;
    logic wrap;

    // Greater-or-equal so that a smaller period restarts the count at once
    assign wrap = count_q >= period[COUNT_WIDTH-1:0];

    always_ff @(posedge clock) begin
        if (!reset) begin
            count_q <= '0;
            counting <= 1'b0;
        end else if (count_enable) begin
            counting <= 1'b1;
            if (wrap) begin
                count_q <= '0;
            end else begin
                count_q <= count_q + 1'b1;
            end
        end else begin
            counting <= 1'b0;
            count_q <= '0;
        end
    end

    // Zero extended to the port width
    assign count = count_t'(count_q);

    idle_count_zero: assert property (
        @(posedge clock) disable iff (!reset)
        !counting |-> (count == '0)
    ) else $error("count is not zero while stopped");

endmodule

//--- hdl/bus_write_fsm.sv
`timescale 1ns/100ps

module bus_write_fsm #(
    parameter enable_gen_pkg::addr_t BASE_ADDRESS = '0,
    parameter int COUNT_WIDTH = enable_gen_pkg::COUNT_WIDTH
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   write_strobe,
    input  enable_gen_pkg::addr_t  address,
    input  enable_gen_pkg::data_t  write_data,
    output logic                   ready,
    output logic                   run_bit,
    output enable_gen_pkg::count_t period,
    output enable_gen_pkg::count_t threshold_1,
    output enable_gen_pkg::count_t threshold_2
);

    import enable_gen_pkg::*;

    // Full register addresses
    localparam addr_t CTRL_ADDRESS = addr_t'(BASE_ADDRESS + CTRL_OFFSET);
    localparam addr_t PERIOD_ADDRESS = addr_t'(BASE_ADDRESS + PERIOD_OFFSET);
    localparam addr_t THRESH1_ADDRESS = addr_t'(BASE_ADDRESS + THRESH1_OFFSET);
    localparam addr_t THRESH2_ADDRESS = addr_t'(BASE_ADDRESS + THRESH2_OFFSET);

    bus_state_t state;
    addr_t latched_address;
    data_t latched_data;
    count_t write_value;
    logic accept;

    // A write is taken only while the machine is waiting
    assign accept = write_strobe && (state == IDLE);

    // Write data cut down to the counter width
    assign write_value = count_t'(latched_data[COUNT_WIDTH-1:0]);

    always_ff @(posedge clock) begin
        if (accept) begin
            latched_address <= address;
            latched_data <= write_data;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= IDLE;
            ready <= 1'b1;
        end else begin
            case (state)
                IDLE: begin
                    if (write_strobe) begin
                        state <= APPLY;
                        ready <= 1'b0;
                    end
                end
                APPLY: begin
                    // Register update happens this cycle, bus is free again next
                    state <= IDLE;
                    ready <= 1'b1;
                end
                default: begin
                    state <= IDLE;
                    ready <= 1'b1;
                end
            endcase
        end
    end

    // Decode of the latched write
    always_ff @(posedge clock) begin
        if (!reset) begin
            run_bit <= 1'b0;
            period <= '0;
            threshold_1 <= '0;
            threshold_2 <= '0;
        end else if (state == APPLY) begin
            case (latched_address)
                CTRL_ADDRESS: begin
                    run_bit <= latched_data[RUN_BIT];
                end
                PERIOD_ADDRESS: begin
                    period <= write_value;
                end
                THRESH1_ADDRESS: begin
                    threshold_1 <= write_value;
                end
                THRESH2_ADDRESS: begin
                    threshold_2 <= write_value;
                end
                default: begin
                    // Unmapped address, nothing changes
                end
            endcase
        end
    end

    // Ready is the only view the bus has of the state
    ready_matches_state: assert property (
        @(posedge clock) disable iff (!reset)
        ready == (state != APPLY)
    ) else $error("ready out of step with bus state");

    state_legal: assert property (
        @(posedge clock) disable iff (!reset)
        state inside {IDLE, APPLY}
    ) else $error("bus state holds an illegal encoding");

endmodule

//--- hdl/enable_gen_pkg.sv
package enable_gen_pkg;

    // Widest count the port types can carry
    parameter int COUNT_WIDTH = 32;

    // Register bus word size
    parameter int BUS_WIDTH = 32;

    typedef logic [COUNT_WIDTH-1:0] count_t;
    typedef logic [BUS_WIDTH-1:0] addr_t;
    typedef logic [BUS_WIDTH-1:0] data_t;

    // Bus write machine states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        APPLY = 2'd1
    } bus_state_t;

    // Register map, relative to the base address
    localparam addr_t CTRL_OFFSET = 32'h0000_0000;
    localparam addr_t PERIOD_OFFSET = 32'h0000_0004;
    localparam addr_t THRESH1_OFFSET = 32'h0000_0008;
    localparam addr_t THRESH2_OFFSET = 32'h0000_000c;

    // Control register fields
    localparam int RUN_BIT = 0;

endpackage
